// File: verilog/ls_pkg.sv
package ls_pkg;

    // datapath and address width
    localparam int XLEN = 32;

    // rob tag and physical register width
    localparam int TAG_W = 6;

    // queue geometry, depth must stay a power of two
    localparam int LSQ_DEPTH = 16;
    localparam int LSQ_IDX_W = 4;

    // functional-unit fill ports
    localparam int NUM_FUNCT = 3;

    // data memory size and decoded address bits
    localparam int MEM_BYTES = 4096;
    localparam int MEM_ADDR_W = 12;

    // cycles from accepted request to done
    localparam int MEM_LATENCY = 10;

    // upper bit set means store
    // lower bit set means byte access
    typedef enum logic [1:0] {
        OP_LW = 2'b00,
        OP_LB = 2'b01,
        OP_SW = 2'b10,
        OP_SB = 2'b11
    } ls_op_e;

    // one queue slot, 78 bits
    // op at the top, store data at the bottom
    typedef struct packed {
        ls_op_e           op;
        logic [TAG_W-1:0] phys_rd;
        logic [TAG_W-1:0] rob_tag;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  data;
    } lsq_entry_t;

endpackage

// File: verilog/lsq_head_if.sv
`timescale 1ns/1ps

// queue head handoff to the memory sequencer
interface lsq_head_if ();

    // head slot allocated and filled
    logic head_ready;

    // head slot contents
    ls_pkg::lsq_entry_t head_entry;

    // single-cycle release of the head slot
    // only legal while head_ready is high
    logic head_pop;

    modport queue_side (
        output head_ready,
        output head_entry,
        input  head_pop
    );

    modport seq_side (
        input  head_ready,
        input  head_entry,
        output head_pop
    );

endinterface

// File: verilog/mem_req_if.sv
`timescale 1ns/1ps

// request/done handshake to the data memory
interface mem_req_if ();

    // request side, req is a single-cycle pulse
    logic                    req;
    logic                    write;
    // byte-wide access, otherwise aligned word
    logic                    byte_en;
    logic [ls_pkg::XLEN-1:0] addr;
    logic [ls_pkg::XLEN-1:0] wdata;

    // completion side, rdata valid with done
    logic                    done;
    logic [ls_pkg::XLEN-1:0] rdata;

    modport requester (
        output req, write, byte_en, addr, wdata,
        input  done, rdata
    );

    modport memory (
        input  req, write, byte_en, addr, wdata,
        output done, rdata
    );

endinterface

// File: verilog/lsq_queue.sv
`timescale 1ns/1ps

module lsq_queue (
    input  logic                                             clk,
    input  logic                                             reset_n,

    // allocation from decode, program order
    input  logic                                             alloc_valid,
    input  ls_pkg::ls_op_e                                   alloc_op,
    input  logic [ls_pkg::TAG_W-1:0]                         alloc_phys_rd,
    input  logic [ls_pkg::TAG_W-1:0]                         alloc_rob_tag,

    // fills from the functional units, any order
    input  logic [ls_pkg::NUM_FUNCT-1:0]                     fill_valid,
    input  logic [ls_pkg::NUM_FUNCT-1:0][ls_pkg::TAG_W-1:0]  fill_rob_tag,
    input  logic [ls_pkg::NUM_FUNCT-1:0][ls_pkg::XLEN-1:0]   fill_addr,
    input  logic [ls_pkg::NUM_FUNCT-1:0][ls_pkg::XLEN-1:0]   fill_data,

    output logic                                             lsq_full,

    lsq_head_if.queue_side                                   head
);

    // occupancy needs one bit more than the index
    typedef logic [ls_pkg::LSQ_IDX_W:0] occ_t;

    // slot payload
    ls_pkg::lsq_entry_t slots [ls_pkg::LSQ_DEPTH];

    // per-slot state
    logic [ls_pkg::LSQ_DEPTH-1:0] slot_valid;
    logic [ls_pkg::LSQ_DEPTH-1:0] slot_ready;

    // circular pointers
    logic [ls_pkg::LSQ_IDX_W-1:0] tail_ptr;
    logic [ls_pkg::LSQ_IDX_W-1:0] head_ptr;
    occ_t                         occupancy;

    logic alloc_fire;

    // tag match per slot and per fill port
    logic [ls_pkg::LSQ_DEPTH-1:0][ls_pkg::NUM_FUNCT-1:0] fill_hit;

    // full queue drops the allocation
    assign alloc_fire = alloc_valid && !lsq_full;

    // occupancy tracks tail minus head including the wrapped case
    assign lsq_full = (occupancy == occ_t'(ls_pkg::LSQ_DEPTH));

    // head view for the sequencer
    assign head.head_ready = slot_valid[head_ptr] && slot_ready[head_ptr];
    assign head.head_entry = slots[head_ptr];

    // only allocated, still unfilled slots can take a fill
    always_comb begin
        for (int i = 0; i < ls_pkg::LSQ_DEPTH; i++) begin
            for (int p = 0; p < ls_pkg::NUM_FUNCT; p++) begin
                fill_hit[i][p] = fill_valid[p] && slot_valid[i] && !slot_ready[i] &&
                                 (slots[i].rob_tag == fill_rob_tag[p]);
            end
        end
    end

    // payload writes
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            slots[tail_ptr].op      <= alloc_op;
            slots[tail_ptr].phys_rd <= alloc_phys_rd;
            slots[tail_ptr].rob_tag <= alloc_rob_tag;
        end
        for (int i = 0; i < ls_pkg::LSQ_DEPTH; i++) begin
            for (int p = 0; p < ls_pkg::NUM_FUNCT; p++) begin
                // ports never share a tag in one cycle
                if (fill_hit[i][p]) begin
                    slots[i].addr <= fill_addr[p];
                    slots[i].data <= fill_data[p];
                end
            end
        end
    end

    // slot flags, pointers and occupancy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slot_valid <= '0;
            slot_ready <= '0;
            tail_ptr   <= '0;
            head_ptr   <= '0;
            occupancy  <= '0;
        end else begin
            if (alloc_fire) begin
                slot_valid[tail_ptr] <= 1'b1;
                slot_ready[tail_ptr] <= 1'b0;
                tail_ptr             <= tail_ptr + 1'b1;
            end
            for (int i = 0; i < ls_pkg::LSQ_DEPTH; i++) begin
                if (|fill_hit[i]) begin
                    slot_ready[i] <= 1'b1;
                end
            end
            // pop hits a filled slot, never the allocation or fill target
            if (head.head_pop) begin
                slot_valid[head_ptr] <= 1'b0;
                slot_ready[head_ptr] <= 1'b0;
                head_ptr             <= head_ptr + 1'b1;
            end
            case ({alloc_fire, head.head_pop})
                2'b10:   occupancy <= occupancy + occ_t'(1);
                2'b01:   occupancy <= occupancy - occ_t'(1);
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

// File: verilog/lsq_mem_sequencer.sv
`timescale 1ns/1ps

module lsq_mem_sequencer (
    input  logic                     clk,
    input  logic                     reset_n,

    lsq_head_if.seq_side             head,
    mem_req_if.requester             mem,

    // wakeup for the issue queue
    output logic                     fwd_valid,
    output logic [ls_pkg::TAG_W-1:0] fwd_phys_rd,
    output logic [ls_pkg::XLEN-1:0]  load_data,

    // retire pulse to the rob
    output logic                     rob_retire_valid,
    output logic [ls_pkg::TAG_W-1:0] rob_retire_tag
);

    typedef enum logic {
        S_IDLE,
        S_WAIT
    } seq_state_e;

    seq_state_e state;

    logic head_is_store;
    logic head_is_byte;

    // decode from the opcode encoding
    assign head_is_store = head.head_entry.op[1];
    assign head_is_byte  = (head.head_entry.op == ls_pkg::OP_LB) ||
                           (head.head_entry.op == ls_pkg::OP_SB);

    // request payload, sampled while idle and held during the wait
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            mem.write   <= head_is_store;
            mem.byte_en <= head_is_byte;
            mem.addr    <= head.head_entry.addr;
            // store byte only carries the low byte
            if (head.head_entry.op == ls_pkg::OP_SB) begin
                mem.wdata <= {{(ls_pkg::XLEN-8){1'b0}}, head.head_entry.data[7:0]};
            end else begin
                mem.wdata <= head.head_entry.data;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state            <= S_IDLE;
            mem.req          <= 1'b0;
            head.head_pop    <= 1'b0;
            fwd_valid        <= 1'b0;
            fwd_phys_rd      <= '0;
            load_data        <= '0;
            rob_retire_valid <= 1'b0;
            rob_retire_tag   <= '0;
        end else begin
            // pulses default low, data outputs back to zero
            mem.req          <= 1'b0;
            head.head_pop    <= 1'b0;
            fwd_valid        <= 1'b0;
            fwd_phys_rd      <= '0;
            load_data        <= '0;
            rob_retire_valid <= 1'b0;
            rob_retire_tag   <= '0;
            case (state)
                S_IDLE: begin
                    // head_ready still shows the popped entry during the pop cycle
                    if (head.head_ready && !head.head_pop) begin
                        mem.req <= 1'b1;
                        state   <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mem.done) begin
                        rob_retire_valid <= 1'b1;
                        rob_retire_tag   <= head.head_entry.rob_tag;
                        head.head_pop    <= 1'b1;
                        state            <= S_IDLE;
                        // loads also wake up their consumers
                        if (!head_is_store) begin
                            fwd_valid   <= 1'b1;
                            fwd_phys_rd <= head.head_entry.phys_rd;
                            if (head_is_byte) begin
                                load_data <= {{(ls_pkg::XLEN-8){1'b0}}, mem.rdata[7:0]};
                            end else begin
                                load_data <= mem.rdata;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/data_memory.sv
`timescale 1ns/1ps

module data_memory (
    input  logic       clk,
    input  logic       reset_n,

    mem_req_if.memory  mem
);

    typedef logic [$clog2(ls_pkg::MEM_LATENCY)-1:0] lat_cnt_t;

    // byte storage, little-endian
    logic [7:0] bytes_q [ls_pkg::MEM_BYTES];

    // access in progress
    logic     busy;
    lat_cnt_t lat_cnt;

    // latched request
    logic                          lat_write;
    logic                          lat_byte;
    logic [ls_pkg::MEM_ADDR_W-1:0] lat_addr;
    logic [ls_pkg::XLEN-1:0]       lat_wdata;

    // aligned word base, low two bits dropped
    logic [ls_pkg::MEM_ADDR_W-3:0] word_base;

    assign word_base = lat_addr[ls_pkg::MEM_ADDR_W-1:2];

    // capture on an accepted request, upper address bits ignored
    always_ff @(posedge clk) begin
        if (mem.req && !busy) begin
            lat_write <= mem.write;
            lat_byte  <= mem.byte_en;
            lat_addr  <= mem.addr[ls_pkg::MEM_ADDR_W-1:0];
            lat_wdata <= mem.wdata;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < ls_pkg::MEM_BYTES; i++) begin
                bytes_q[i] <= 8'h00;
            end
            busy      <= 1'b0;
            lat_cnt   <= '0;
            mem.done  <= 1'b0;
            mem.rdata <= '0;
        end else begin
            mem.done <= 1'b0;
            if (!busy) begin
                // requests while busy are not accepted
                if (mem.req) begin
                    busy    <= 1'b1;
                    lat_cnt <= lat_cnt_t'(ls_pkg::MEM_LATENCY - 1);
                end
            end else if (lat_cnt == lat_cnt_t'(1)) begin
                // last count, done shows up on the next cycle
                busy     <= 1'b0;
                mem.done <= 1'b1;
                if (lat_write) begin
                    if (lat_byte) begin
                        bytes_q[lat_addr] <= lat_wdata[7:0];
                    end else begin
                        for (int k = 0; k < 4; k++) begin
                            bytes_q[{word_base, 2'(k)}] <= lat_wdata[8*k +: 8];
                        end
                    end
                end else if (lat_byte) begin
                    mem.rdata <= {{(ls_pkg::XLEN-8){1'b0}}, bytes_q[lat_addr]};
                end else begin
                    mem.rdata <= {bytes_q[{word_base, 2'd3}], bytes_q[{word_base, 2'd2}],
                                  bytes_q[{word_base, 2'd1}], bytes_q[{word_base, 2'd0}]};
                end
            end else begin
                lat_cnt <= lat_cnt - lat_cnt_t'(1);
            end
        end
    end

endmodule

// File: verilog/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic                     clk,
    input  logic                     reset_n,

    // decode allocation
    input  logic                     alloc_valid,
    input  ls_pkg::ls_op_e           alloc_op,
    input  logic [ls_pkg::TAG_W-1:0] alloc_phys_rd,
    input  logic [ls_pkg::TAG_W-1:0] alloc_rob_tag,

    // functional unit 0
    input  logic                     funct0_valid,
    input  logic [ls_pkg::TAG_W-1:0] funct0_rob_tag,
    input  logic [ls_pkg::XLEN-1:0]  funct0_addr,
    input  logic [ls_pkg::XLEN-1:0]  funct0_data,

    // functional unit 1
    input  logic                     funct1_valid,
    input  logic [ls_pkg::TAG_W-1:0] funct1_rob_tag,
    input  logic [ls_pkg::XLEN-1:0]  funct1_addr,
    input  logic [ls_pkg::XLEN-1:0]  funct1_data,

    // functional unit 2
    input  logic                     funct2_valid,
    input  logic [ls_pkg::TAG_W-1:0] funct2_rob_tag,
    input  logic [ls_pkg::XLEN-1:0]  funct2_addr,
    input  logic [ls_pkg::XLEN-1:0]  funct2_data,

    output logic                     lsq_full,

    output logic                     fwd_valid,
    output logic [ls_pkg::TAG_W-1:0] fwd_phys_rd,
    output logic [ls_pkg::XLEN-1:0]  load_data,

    output logic                     rob_retire_valid,
    output logic [ls_pkg::TAG_W-1:0] rob_retire_tag
);

    // fill ports gathered into arrays, port n at index n
    logic [ls_pkg::NUM_FUNCT-1:0]                    fill_valid;
    logic [ls_pkg::NUM_FUNCT-1:0][ls_pkg::TAG_W-1:0] fill_rob_tag;
    logic [ls_pkg::NUM_FUNCT-1:0][ls_pkg::XLEN-1:0]  fill_addr;
    logic [ls_pkg::NUM_FUNCT-1:0][ls_pkg::XLEN-1:0]  fill_data;

    assign fill_valid   = {funct2_valid, funct1_valid, funct0_valid};
    assign fill_rob_tag = {funct2_rob_tag, funct1_rob_tag, funct0_rob_tag};
    assign fill_addr    = {funct2_addr, funct1_addr, funct0_addr};
    assign fill_data    = {funct2_data, funct1_data, funct0_data};

    lsq_head_if head_bus ();
    mem_req_if  mem_bus ();

    lsq_queue i_queue (
        .clk           (clk),
        .reset_n       (reset_n),
        .alloc_valid   (alloc_valid),
        .alloc_op      (alloc_op),
        .alloc_phys_rd (alloc_phys_rd),
        .alloc_rob_tag (alloc_rob_tag),
        .fill_valid    (fill_valid),
        .fill_rob_tag  (fill_rob_tag),
        .fill_addr     (fill_addr),
        .fill_data     (fill_data),
        .lsq_full      (lsq_full),
        .head          (head_bus.queue_side)
    );

    lsq_mem_sequencer i_sequencer (
        .clk              (clk),
        .reset_n          (reset_n),
        .head             (head_bus.seq_side),
        .mem              (mem_bus.requester),
        .fwd_valid        (fwd_valid),
        .fwd_phys_rd      (fwd_phys_rd),
        .load_data        (load_data),
        .rob_retire_valid (rob_retire_valid),
        .rob_retire_tag   (rob_retire_tag)
    );

    data_memory i_memory (
        .clk     (clk),
        .reset_n (reset_n),
        .mem     (mem_bus.memory)
    );

endmodule

// File: verif/load_store_sva.sv
`timescale 1ns/1ps

module load_store_sva (
    input logic clk,
    input logic reset_n,
    input logic head_ready,
    input logic head_pop,
    input logic req,
    input logic done
);

    // memory access between req and done
    logic outstanding;
    // cycles since the last accepted req
    logic [7:0] req_age;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            outstanding <= 1'b0;
            req_age     <= '0;
        end else if (req) begin
            outstanding <= 1'b1;
            req_age     <= 8'd1;
        end else if (done) begin
            outstanding <= 1'b0;
        end else if (outstanding) begin
            req_age <= req_age + 8'd1;
        end
    end

    // pop only releases a filled head
    pop_needs_ready: assert property (@(posedge clk) disable iff (!reset_n)
        head_pop |-> head_ready)
        else $error("head_pop without head_ready");

    // one access at a time in the memory
    no_req_in_flight: assert property (@(posedge clk) disable iff (!reset_n)
        outstanding |-> !req)
        else $error("req issued while a request is outstanding");

    // done lands exactly one memory latency after its req
    done_on_latency: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> (outstanding && (req_age == 8'(ls_pkg::MEM_LATENCY))))
        else $error("done not MEM_LATENCY cycles after its req");

endmodule

bind lsq_mem_sequencer load_store_sva i_sva (
    .clk        (clk),
    .reset_n    (reset_n),
    .head_ready (head.head_ready),
    .head_pop   (head.head_pop),
    .req        (mem.req),
    .done       (mem.done)
);

// File: verif/tb_load_store.sv
`timescale 1ns/1ps

module tb_load_store;

    localparam int NUM_ROWS = 18;
    // table rows plus the full-queue pass, each bounded by one memory access
    localparam int WATCHDOG_NS = (NUM_ROWS + 17) * (ls_pkg::MEM_LATENCY + 4) * 10 + 5000;

    typedef struct packed {
        ls_pkg::ls_op_e op;
        logic [31:0]    addr;
        logic [31:0]    data;
        logic           batch_end;
    } stim_row_t;

    // one expected retire, in program order
    typedef struct {
        logic [5:0]  tag;
        logic [5:0]  phys_rd;
        logic        is_load;
        logic [31:0] data;
    } exp_t;

    logic clk = 1'b0;
    logic reset_n;
    logic alloc_valid;
    ls_pkg::ls_op_e alloc_op;
    logic [5:0] alloc_phys_rd;
    logic [5:0] alloc_rob_tag;
    logic f_valid [3];
    logic [5:0] f_tag [3];
    logic [31:0] f_addr [3];
    logic [31:0] f_data [3];
    logic lsq_full;
    logic fwd_valid;
    logic [5:0] fwd_phys_rd;
    logic [31:0] load_data;
    logic rob_retire_valid;
    logic [5:0] rob_retire_tag;

    stim_row_t stim_table [NUM_ROWS];
    logic [7:0] ref_mem [4096];
    exp_t exp_q [$];
    // pending fills of the current batch and their fill order
    logic [5:0] pend_tag [16];
    logic [31:0] pend_addr [16];
    logic [31:0] pend_data [16];
    int order [16];
    logic [31:0] lfsr_state = 32'h2c7b_f7b2;
    logic [5:0] next_tag;
    int alloc_count;
    int retired_count;

    always #5 clk = ~clk;

    load_store_unit i_dut (
        .clk (clk), .reset_n (reset_n),
        .alloc_valid (alloc_valid), .alloc_op (alloc_op),
        .alloc_phys_rd (alloc_phys_rd), .alloc_rob_tag (alloc_rob_tag),
        .funct0_valid (f_valid[0]), .funct0_rob_tag (f_tag[0]),
        .funct0_addr (f_addr[0]), .funct0_data (f_data[0]),
        .funct1_valid (f_valid[1]), .funct1_rob_tag (f_tag[1]),
        .funct1_addr (f_addr[1]), .funct1_data (f_data[1]),
        .funct2_valid (f_valid[2]), .funct2_rob_tag (f_tag[2]),
        .funct2_addr (f_addr[2]), .funct2_data (f_data[2]),
        .lsq_full (lsq_full),
        .fwd_valid (fwd_valid), .fwd_phys_rd (fwd_phys_rd), .load_data (load_data),
        .rob_retire_valid (rob_retire_valid), .rob_retire_tag (rob_retire_tag)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", msg);
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // little-endian reference, 12 address bits, word accesses aligned down
    function automatic logic [31:0] ref_access(input ls_pkg::ls_op_e op,
                                               input logic [31:0] addr,
                                               input logic [31:0] data);
        int a;
        int w;
        logic [31:0] result;
        a = int'(addr[11:0]);
        w = a & 32'hffc;
        result = '0;
        case (op)
            ls_pkg::OP_SW: begin
                for (int k = 0; k < 4; k++) begin
                    ref_mem[w + k] = data[8*k +: 8];
                end
            end
            ls_pkg::OP_SB: ref_mem[a] = data[7:0];
            ls_pkg::OP_LW: result = {ref_mem[w+3], ref_mem[w+2], ref_mem[w+1], ref_mem[w]};
            default:       result = {24'h0, ref_mem[a]};
        endcase
        return result;
    endfunction

    task automatic load_table();
        // unwritten address reads zero
        stim_table[0]  = '{ls_pkg::OP_LW, 32'h0000_0100, 32'h0,         1'b1};
        // byte store into a known word
        stim_table[1]  = '{ls_pkg::OP_SW, 32'h0000_0040, 32'h1234_5678, 1'b0};
        stim_table[2]  = '{ls_pkg::OP_LW, 32'h0000_0040, 32'h0,         1'b0};
        stim_table[3]  = '{ls_pkg::OP_SB, 32'h0000_0041, 32'hffff_ffab, 1'b0};
        stim_table[4]  = '{ls_pkg::OP_LW, 32'h0000_0040, 32'h0,         1'b0};
        stim_table[5]  = '{ls_pkg::OP_LB, 32'h0000_0041, 32'h0,         1'b1};
        // full batch of eight, 0x1204 aliases 0x204
        stim_table[6]  = '{ls_pkg::OP_SW, 32'h0000_0200, 32'hdead_beef, 1'b0};
        stim_table[7]  = '{ls_pkg::OP_SW, 32'h0000_1204, 32'hcafe_f00d, 1'b0};
        stim_table[8]  = '{ls_pkg::OP_SB, 32'h0000_0206, 32'h0000_005a, 1'b0};
        stim_table[9]  = '{ls_pkg::OP_LW, 32'h0000_0200, 32'h0,         1'b0};
        stim_table[10] = '{ls_pkg::OP_LB, 32'h0000_0203, 32'h0,         1'b0};
        stim_table[11] = '{ls_pkg::OP_LW, 32'h0000_0206, 32'h0,         1'b0};
        stim_table[12] = '{ls_pkg::OP_LB, 32'h0000_0206, 32'h0,         1'b0};
        stim_table[13] = '{ls_pkg::OP_LW, 32'h0000_0204, 32'h0,         1'b1};
        // top of memory
        stim_table[14] = '{ls_pkg::OP_SB, 32'h0000_0fff, 32'h0000_0077, 1'b0};
        stim_table[15] = '{ls_pkg::OP_LB, 32'h0000_0fff, 32'h0,         1'b0};
        stim_table[16] = '{ls_pkg::OP_LW, 32'h0000_0ffe, 32'h0,         1'b0};
        stim_table[17] = '{ls_pkg::OP_LB, 32'h0000_0040, 32'h0,         1'b1};
    endtask

    // one allocation per call, expected result taken in program order
    task automatic allocate_entry(input ls_pkg::ls_op_e op, input logic [31:0] addr,
                                  input logic [31:0] data, input int slot);
        exp_t e;
        @(posedge clk);
        #1;
        alloc_valid   = 1'b1;
        alloc_op      = op;
        alloc_rob_tag = next_tag;
        alloc_phys_rd = next_tag ^ 6'h15;
        pend_tag[slot]  = next_tag;
        pend_addr[slot] = addr;
        pend_data[slot] = data;
        e.tag     = next_tag;
        e.phys_rd = next_tag ^ 6'h15;
        e.is_load = (op == ls_pkg::OP_LW) || (op == ls_pkg::OP_LB);
        e.data    = ref_access(op, addr, data);
        exp_q.push_back(e);
        next_tag = next_tag + 6'd1;
        alloc_count++;
    endtask

    task automatic shuffle_order(input int n);
        int j;
        int t;
        for (int i = 0; i < n; i++) begin
            order[i] = i;
        end
        for (int i = n - 1; i > 0; i--) begin
            j = int'(lfsr_bits(4)) % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
    endtask

    // each port takes the next permuted entry on a random bit
    task automatic fill_entries(input int n);
        int next;
        next = 0;
        while (next < n) begin
            @(posedge clk);
            #1;
            for (int p = 0; p < 3; p++) begin
                f_valid[p] = 1'b0;
                if (next < n && lfsr_step()) begin
                    f_valid[p] = 1'b1;
                    f_tag[p]   = pend_tag[order[next]];
                    f_addr[p]  = pend_addr[order[next]];
                    f_data[p]  = pend_data[order[next]];
                    next++;
                end
            end
        end
        @(posedge clk);
        #1;
        for (int p = 0; p < 3; p++) begin
            f_valid[p] = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic run_batch(input int first, input int last);
        int n;
        n = 0;
        for (int r = first; r <= last; r++) begin
            allocate_entry(stim_table[r].op, stim_table[r].addr, stim_table[r].data, n);
            n++;
        end
        @(posedge clk);
        #1 alloc_valid = 1'b0;
        shuffle_order(n);
        fill_entries(n);
        wait_drain();
    endtask

    task automatic full_queue_test();
        ls_pkg::ls_op_e op;
        for (int i = 0; i < 16; i++) begin
            op = (i % 2 == 0) ? ls_pkg::OP_SW : ls_pkg::OP_LW;
            allocate_entry(op, 32'h800 + 32'(4 * (i / 2)), lfsr_bits(32), i);
        end
        @(posedge clk);
        #1;
        check_value("lsq_full", 32'(lsq_full), 32'd1);
        // 17th allocation lands on a full queue, never filled or expected
        alloc_op      = ls_pkg::OP_LW;
        alloc_rob_tag = next_tag;
        alloc_phys_rd = next_tag ^ 6'h15;
        next_tag = next_tag + 6'd1;
        @(posedge clk);
        #1 alloc_valid = 1'b0;
        check_value("lsq_full", 32'(lsq_full), 32'd1);
        repeat (5) @(posedge clk);
        shuffle_order(16);
        fill_entries(16);
        wait_drain();
        check_value("lsq_full", 32'(lsq_full), 32'd0);
    endtask

    // outputs settle after the rising edge, compared on the falling edge
    always @(negedge clk) begin : retire_monitor
        exp_t e;
        if (reset_n === 1'b1) begin
            if (fwd_valid && !rob_retire_valid) begin
                report_error("forward pulse seen without a retire pulse");
            end
            if (rob_retire_valid) begin
                if (exp_q.size() == 0) begin
                    report_error("retire pulse seen with no entry outstanding");
                end
                e = exp_q.pop_front();
                retired_count++;
                check_value("rob_retire_tag", 32'(rob_retire_tag), 32'(e.tag));
                check_value("fwd_valid", 32'(fwd_valid), 32'(e.is_load));
                if (e.is_load) begin
                    check_value("fwd_phys_rd", 32'(fwd_phys_rd), 32'(e.phys_rd));
                    check_value("load_data", load_data, e.data);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR the run timed out before all entries retired");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_seq
        int first;
        alloc_valid   = 1'b0;
        alloc_op      = ls_pkg::OP_LW;
        alloc_phys_rd = '0;
        alloc_rob_tag = '0;
        for (int p = 0; p < 3; p++) begin
            f_valid[p] = 1'b0;
            f_tag[p]   = '0;
            f_addr[p]  = '0;
            f_data[p]  = '0;
        end
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = 8'h00;
        end
        next_tag      = 6'd1;
        alloc_count   = 0;
        retired_count = 0;
        load_table();
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;
        // quiet after reset, any pulse trips the monitor
        repeat (20) @(posedge clk);
        first = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (stim_table[r].batch_end) begin
                run_batch(first, r);
                first = r + 1;
            end
        end
        full_queue_test();
        repeat (5) @(posedge clk);
        if (exp_q.size() == 0 && retired_count == alloc_count) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("ERROR retire count %0d does not match allocations %0d",
                     retired_count, alloc_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "retire count mismatch");
        end
    end

endmodule

// File: vlog.f
verilog/ls_pkg.sv
verilog/lsq_head_if.sv
verilog/mem_req_if.sv
verilog/lsq_queue.sv
verilog/lsq_mem_sequencer.sv
verilog/data_memory.sv
verilog/load_store_unit.sv
verif/load_store_sva.sv
verif/tb_load_store.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_load_store -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished cleanly"
